//--- vlog.f
csrPkg.sv
csrBusPort.sv
privilegeControl.sv
trapLevelRegs.sv
csrTop.sv
csrTb.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build csrTb with Verilator, run it and check $(LOG) for the pass line"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f vlog.f --top-module csrTb -Mdir obj_dir -o csrSim
	./obj_dir/csrSim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- csrTb.sv
// Testbench for the CSR unit; drives Wishbone and trap stimulus and checks reads against a model
`timescale 1ns/10ps
`default_nettype none

module csrTb;
    import csrPkg::*;

    localparam word_t    HartIdValue = 32'h0000_0005;
    localparam int       CycleLimit  = 4000;
    localparam int       AckLimit    = 8;
    localparam csrAddr_t AddrMstatus = 12'h300;
    localparam csrAddr_t AddrMedeleg = 12'h302;
    localparam csrAddr_t AddrSstatus = 12'h100;
    localparam csrOffset_t TrapOffsets [5] = '{OffTvec, OffScratch, OffEpc, OffCause, OffTval};

    logic       clk = 1'b0;
    logic       rst;
    logic       wbCyc;
    logic       wbStb;
    logic       wbWe;
    csrAddr_t   wbAdr;
    word_t      wbDatW;
    word_t      wbDatR;
    logic       wbAck;
    logic       trapValid;
    cause_t     trapCause;
    word_t      trapValue;
    word_t      trapPc;
    logic       trapReturn;
    privilege_t returnPriv;
    word_t      nextPc;
    privilege_t privilege;

    // Register model, index 0 is machine and 1 is supervisor
    word_t       modelStatus;
    word_t       modelEdeleg;
    word_t       modelTvec [2];
    word_t       modelScratch [2];
    word_t       modelEpc [2];
    word_t       modelCause [2];
    word_t       modelTval [2];
    privilege_t  modelPriv;
    logic [63:0] modelCycle;

    word_t lfsrState;
    word_t lastRead;
    word_t expRead;
    word_t expPc;
    logic  ackPrev = 1'b0;
    int    lastAckEdge;
    int    cycleNum = 0;
    int    checkCount = 0;
    int    errorCount = 0;

    csrTop #(
        .HartId(HartIdValue)
    ) dut (
        .clk(clk), .rst(rst),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW),
        .wbDatR(wbDatR), .wbAck(wbAck),
        .trapValid(trapValid), .trapCause(trapCause), .trapValue(trapValue),
        .trapPc(trapPc), .trapReturn(trapReturn), .returnPriv(returnPriv),
        .nextPc(nextPc), .privilege(privilege)
    );

    always #50 clk = ~clk;

    // ------------------------------------------------------------------------
    // Random source and reference model
    // ------------------------------------------------------------------------

    // Galois form, polynomial x^32 + x^22 + x^2 + x + 1
    function automatic word_t lfsrStep(input word_t state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    function automatic word_t randomBits(input int count);
        word_t value;
        int    i;
        value = '0;
        for (i = 0; i < count; i++) begin
            lfsrState = lfsrStep(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic csrAddr_t trapRegAddr(input int lvl, input csrOffset_t off);
        return (lvl == 0) ? {4'h3, off} : {4'h1, off};
    endfunction

    function automatic word_t expectedRead(input csrAddr_t addr);
        word_t value;
        int    lvl;
        value = '0;
        if (addr == AddrMisa)    value = MisaValue;
        if (addr == AddrMhartid) value = HartIdValue;
        if (addr == AddrCycle)   value = modelCycle[31:0];
        if (addr == AddrCycleh)  value = modelCycle[63:32];
        if (addr == AddrMstatus) value = modelStatus;
        if (addr == AddrSstatus) value = modelStatus & SstatusMask;
        if (addr == AddrMedeleg) value = modelEdeleg;
        for (lvl = 0; lvl < 2; lvl++) begin
            if (addr == trapRegAddr(lvl, OffTvec))    value = modelTvec[lvl];
            if (addr == trapRegAddr(lvl, OffScratch)) value = modelScratch[lvl];
            if (addr == trapRegAddr(lvl, OffEpc))     value = modelEpc[lvl];
            if (addr == trapRegAddr(lvl, OffCause))   value = modelCause[lvl];
            if (addr == trapRegAddr(lvl, OffTval))    value = modelTval[lvl];
        end
        return value;
    endfunction

    function automatic word_t expectedNextPc(input logic isTrap, input logic isReturn,
                                             input cause_t cause, input privilege_t retPriv);
        if (isTrap) begin
            return modelEdeleg[cause] ? modelTvec[1] : modelTvec[0];
        end
        if (isReturn) begin
            return (retPriv == PrivMachine) ? modelEpc[0] : modelEpc[1];
        end
        return '0;
    endfunction

    task automatic applyWrite(input csrAddr_t addr, input word_t data);
        int lvl;
        if (addr == AddrMstatus) modelStatus = data & MstatusMask;
        if (addr == AddrSstatus) modelStatus = (modelStatus & ~SstatusMask) | (data & SstatusMask);
        if (addr == AddrMedeleg) modelEdeleg = data;
        for (lvl = 0; lvl < 2; lvl++) begin
            if (addr == trapRegAddr(lvl, OffTvec))    modelTvec[lvl] = data & ~32'h3;
            if (addr == trapRegAddr(lvl, OffScratch)) modelScratch[lvl] = data;
            if (addr == trapRegAddr(lvl, OffEpc))     modelEpc[lvl] = data;
            if (addr == trapRegAddr(lvl, OffCause))   modelCause[lvl] = data & 32'hF;
            if (addr == trapRegAddr(lvl, OffTval))    modelTval[lvl] = data;
        end
    endtask

    task automatic applyTrap(input cause_t cause, input word_t value, input word_t pc);
        int lvl;
        lvl = modelEdeleg[cause] ? 1 : 0;
        modelEpc[lvl]   = pc;
        modelCause[lvl] = word_t'(cause);
        modelTval[lvl]  = value;
        if (lvl == 0) begin
            modelStatus[StMpie]           = modelStatus[StMie];
            modelStatus[StMie]            = 1'b0;
            modelStatus[StMppHi:StMppLo]  = modelPriv;
            modelPriv                     = PrivMachine;
        end else begin
            modelStatus[StSpie] = modelStatus[StSie];
            modelStatus[StSie]  = 1'b0;
            modelStatus[StSpp]  = modelPriv[0];
            modelPriv           = PrivSupervisor;
        end
    endtask

    task automatic applyReturn(input privilege_t retPriv);
        if (retPriv == PrivMachine) begin
            modelPriv                    = privilege_t'(modelStatus[StMppHi:StMppLo]);
            modelStatus[StMie]           = modelStatus[StMpie];
            modelStatus[StMpie]          = 1'b1;
            modelStatus[StMppHi:StMppLo] = 2'b00;
        end else begin
            modelPriv           = modelStatus[StSpp] ? PrivSupervisor : PrivUser;
            modelStatus[StSie]  = modelStatus[StSpie];
            modelStatus[StSpie] = 1'b1;
            modelStatus[StSpp]  = 1'b0;
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------------------

    task automatic busTransfer(input logic write, input csrAddr_t addr, input word_t data);
        int   waited;
        logic gotAck;
        waited = 0;
        gotAck = 1'b0;
        @(posedge clk);
        wbCyc  <= 1'b1;
        wbStb  <= 1'b1;
        wbWe   <= write;
        wbAdr  <= addr;
        wbDatW <= data;
        do begin
            @(posedge clk);
            gotAck = wbAck;
            waited++;
        end while (!gotAck && waited < AckLimit);
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
        wbWe  <= 1'b0;
        if (!gotAck) begin
            $display("Error at %0t: no Wishbone ack for address %h", $time, addr);
            errorCount++;
        end else begin
            // Ack belongs to the cycle after the request is first sampled
            checkCount++;
            if (waited != 2) begin
                $display("** Error at %0t: wbAck seen after %0d edges, expected 2",
                         $time, waited);
                errorCount++;
            end
            if (write) begin
                applyWrite(addr, data);
            end
        end
    endtask

    task automatic writeCsr(input csrAddr_t addr, input word_t data);
        busTransfer(1'b1, addr, data);
    endtask

    task automatic readCsr(input csrAddr_t addr);
        busTransfer(1'b0, addr, '0);
    endtask

    task automatic raiseTrap(input cause_t cause, input word_t value, input word_t pc);
        @(posedge clk);
        trapValid <= 1'b1;
        trapCause <= cause;
        trapValue <= value;
        trapPc    <= pc;
        @(posedge clk);
        trapValid <= 1'b0;
        applyTrap(cause, value, pc);
    endtask

    task automatic returnFrom(input privilege_t retPriv);
        @(posedge clk);
        trapReturn <= 1'b1;
        returnPriv <= retPriv;
        @(posedge clk);
        trapReturn <= 1'b0;
        applyReturn(retPriv);
    endtask

    // ------------------------------------------------------------------------
    // Comparison, counters and timeout
    // ------------------------------------------------------------------------

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (wbAck && !wbWe) begin
                expRead = expectedRead(wbAdr);
                lastRead = wbDatR;
                lastAckEdge = cycleNum;
                checkCount++;
                if (wbDatR !== expRead) begin
                    $display("** Error at %0t: wbDatR = %h, expected %h (address %h)",
                             $time, wbDatR, expRead, wbAdr);
                    errorCount++;
                end
            end
            // Ack lasts one cycle and is followed by an idle cycle
            checkCount++;
            if (wbAck && ackPrev) begin
                $display("** Error at %0t: wbAck = 1, expected 0 after an ack cycle", $time);
                errorCount++;
            end
            ackPrev = wbAck;
            expPc = expectedNextPc(trapValid, trapReturn, trapCause, returnPriv);
            checkCount++;
            if (nextPc !== expPc) begin
                $display("** Error at %0t: nextPc = %h, expected %h", $time, nextPc, expPc);
                errorCount++;
            end
            checkCount++;
            if (privilege !== modelPriv) begin
                $display("** Error at %0t: privilege = %0d, expected %0d",
                         $time, privilege, modelPriv);
                errorCount++;
            end
        end
    end

    always @(posedge clk) begin
        cycleNum = cycleNum + 1;
        if (rst) begin
            modelCycle <= '0;
        end else begin
            modelCycle <= modelCycle + 64'd1;
        end
        if (cycleNum >= CycleLimit) begin
            $display("Error: run did not finish within %0d cycles", CycleLimit);
            $display("Checks: %0d, errors: %0d", checkCount, errorCount + 1);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------

    initial begin
        int    lvl;
        int    k;
        word_t firstCycle;
        int    firstEdge;
        rst = 1'b1;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = '0;
        wbDatW = '0;
        trapValid = 1'b0;
        trapCause = '0;
        trapValue = '0;
        trapPc = '0;
        trapReturn = 1'b0;
        returnPriv = PrivMachine;
        modelStatus = '0;
        modelEdeleg = '0;
        modelTvec = '{'0, '0};
        modelScratch = '{'0, '0};
        modelEpc = '{'0, '0};
        modelCause = '{'0, '0};
        modelTval = '{'0, '0};
        modelPriv = PrivMachine;
        lfsrState = 32'd43;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Reset values, identity and unmapped addresses
        readCsr(AddrMisa);
        readCsr(AddrMhartid);
        readCsr(AddrMstatus);
        readCsr(AddrSstatus);
        readCsr(AddrMedeleg);
        for (lvl = 0; lvl < 2; lvl++) begin
            for (k = 0; k < 5; k++) readCsr(trapRegAddr(lvl, TrapOffsets[k]));
        end
        readCsr(12'hF11);
        readCsr(12'h180);
        readCsr(12'h7C0);

        // Random trap register contents, read back through the masks
        for (lvl = 0; lvl < 2; lvl++) begin
            for (k = 0; k < 5; k++) writeCsr(trapRegAddr(lvl, TrapOffsets[k]), randomBits(32));
        end
        for (lvl = 0; lvl < 2; lvl++) begin
            for (k = 0; k < 5; k++) readCsr(trapRegAddr(lvl, TrapOffsets[k]));
        end

        // sstatus is a masked view of mstatus
        writeCsr(AddrSstatus, randomBits(32));
        readCsr(AddrMstatus);
        readCsr(AddrSstatus);
        writeCsr(AddrMstatus, randomBits(32));
        readCsr(AddrMstatus);
        readCsr(AddrSstatus);

        // Undelegated trap lands in machine mode
        writeCsr(AddrMedeleg, 32'h0);
        writeCsr(AddrMstatus, 32'h0000_0008);
        raiseTrap(4'd2, randomBits(32), randomBits(32));
        readCsr(trapRegAddr(0, OffEpc));
        readCsr(trapRegAddr(0, OffCause));
        readCsr(trapRegAddr(0, OffTval));
        readCsr(AddrMstatus);

        // mret to user, delegated trap, sret, then mret into supervisor
        writeCsr(AddrMstatus, 32'h0000_0080);
        returnFrom(PrivMachine);
        readCsr(AddrMstatus);
        writeCsr(AddrMedeleg, 32'h0000_0100);
        raiseTrap(4'd8, randomBits(32), randomBits(32));
        readCsr(trapRegAddr(1, OffEpc));
        readCsr(trapRegAddr(1, OffCause));
        readCsr(trapRegAddr(1, OffTval));
        readCsr(AddrSstatus);
        returnFrom(PrivSupervisor);
        readCsr(AddrSstatus);
        writeCsr(AddrMstatus, 32'h0000_0800);
        returnFrom(PrivMachine);
        readCsr(AddrMstatus);

        // Cycle counter advances once per clock
        readCsr(AddrCycle);
        firstCycle = lastRead;
        firstEdge = lastAckEdge;
        repeat (5) @(posedge clk);
        readCsr(AddrCycle);
        checkCount++;
        if ((lastRead - firstCycle) != word_t'(lastAckEdge - firstEdge)) begin
            $display("** Error at %0t: cycle advanced %0d, expected %0d",
                     $time, lastRead - firstCycle, lastAckEdge - firstEdge);
            errorCount++;
        end
        readCsr(AddrCycleh);

        repeat (2) @(posedge clk);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- csrTop.sv
// CSR unit top level; joins the Wishbone port, privilege control and the machine and supervisor traps
`timescale 1ns/10ps
`default_nettype none

module csrTop #(
    parameter csrPkg::word_t HartId = '0
) (
    input  logic               clk,
    input  logic               rst,

    // Wishbone classic slave
    input  logic               wbCyc,
    input  logic               wbStb,
    input  logic               wbWe,
    input  csrPkg::csrAddr_t   wbAdr,
    input  csrPkg::word_t      wbDatW,
    output csrPkg::word_t      wbDatR,
    output logic               wbAck,

    // Trap port from the pipeline
    input  logic               trapValid,
    input  csrPkg::cause_t     trapCause,
    input  csrPkg::word_t      trapValue,
    input  csrPkg::word_t      trapPc,
    input  logic               trapReturn,
    input  csrPkg::privilege_t returnPriv,

    output csrPkg::word_t      nextPc,
    output csrPkg::privilege_t privilege
);
    import csrPkg::*;

    logic     regWrite;
    csrAddr_t regAddr;
    word_t    regWData;
    word_t    privRData;
    word_t    machineRData;
    word_t    supervisorRData;
    logic     trapToMachine;
    logic     trapToSupervisor;
    word_t    mHandlerPc;
    word_t    sHandlerPc;
    word_t    mEpc;
    word_t    sEpc;

    csrBusPort #(
        .HartId(HartId)
    ) busPort (
        .clk(clk),
        .rst(rst),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbAdr(wbAdr),
        .wbDatW(wbDatW),
        .wbDatR(wbDatR),
        .wbAck(wbAck),
        .privRData(privRData),
        .machineRData(machineRData),
        .supervisorRData(supervisorRData),
        .regWrite(regWrite),
        .regAddr(regAddr),
        .regWData(regWData)
    );

    privilegeControl privCtrl (
        .clk(clk),
        .rst(rst),
        .regWrite(regWrite),
        .regAddr(regAddr),
        .regWData(regWData),
        .regRData(privRData),
        .trapValid(trapValid),
        .trapCause(trapCause),
        .trapReturn(trapReturn),
        .returnPriv(returnPriv),
        .mHandlerPc(mHandlerPc),
        .sHandlerPc(sHandlerPc),
        .mEpc(mEpc),
        .sEpc(sEpc),
        .trapToMachine(trapToMachine),
        .trapToSupervisor(trapToSupervisor),
        .nextPc(nextPc),
        .privilege(privilege)
    );

    trapLevelRegs #(
        .LevelPriv(PrivMachine)
    ) machineRegs (
        .clk(clk),
        .rst(rst),
        .regWrite(regWrite),
        .regAddr(regAddr),
        .regWData(regWData),
        .regRData(machineRData),
        .trapEnter(trapToMachine),
        .trapCause(trapCause),
        .trapValue(trapValue),
        .trapPc(trapPc),
        .handlerPc(mHandlerPc),
        .epc(mEpc)
    );

    trapLevelRegs #(
        .LevelPriv(PrivSupervisor)
    ) supervisorRegs (
        .clk(clk),
        .rst(rst),
        .regWrite(regWrite),
        .regAddr(regAddr),
        .regWData(regWData),
        .regRData(supervisorRData),
        .trapEnter(trapToSupervisor),
        .trapCause(trapCause),
        .trapValue(trapValue),
        .trapPc(trapPc),
        .handlerPc(sHandlerPc),
        .epc(sEpc)
    );

endmodule

`default_nettype wire

//--- trapLevelRegs.sv
// Trap vector, scratch, epc, cause and tval of one privilege level, selected by LevelPriv
`timescale 1ns/10ps
`default_nettype none

module trapLevelRegs #(
    parameter csrPkg::privilege_t LevelPriv = csrPkg::PrivMachine
) (
    input  logic             clk,
    input  logic             rst,

    // Register access from the bus port
    input  logic             regWrite,
    input  csrPkg::csrAddr_t regAddr,
    input  csrPkg::word_t    regWData,
    output csrPkg::word_t    regRData,

    // Trap entry into this level
    input  logic             trapEnter,
    input  csrPkg::cause_t   trapCause,
    input  csrPkg::word_t    trapValue,
    input  csrPkg::word_t    trapPc,

    output csrPkg::word_t    handlerPc,
    output csrPkg::word_t    epc
);
    import csrPkg::*;

    localparam csrAddr_t AddrTvec    = levelAddr(LevelPriv, OffTvec);
    localparam csrAddr_t AddrScratch = levelAddr(LevelPriv, OffScratch);
    localparam csrAddr_t AddrEpc     = levelAddr(LevelPriv, OffEpc);
    localparam csrAddr_t AddrCause   = levelAddr(LevelPriv, OffCause);
    localparam csrAddr_t AddrTval    = levelAddr(LevelPriv, OffTval);

    // Base only, mode bits are not kept
    logic [29:0] tvecBase;
    word_t       scratch;
    cause_t      cause;
    word_t       tval;

    // ------------------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            tvecBase <= '0;
            scratch  <= '0;
            epc      <= '0;
            cause    <= '0;
            tval     <= '0;
        end else begin
            if (regWrite && regAddr == AddrTvec) begin
                tvecBase <= regWData[31:2];
            end
            if (regWrite && regAddr == AddrScratch) begin
                scratch <= regWData;
            end

            // Trap entry beats a bus write to the same register
            if (trapEnter) begin
                epc   <= trapPc;
                cause <= trapCause;
                tval  <= trapValue;
            end else begin
                if (regWrite && regAddr == AddrEpc) begin
                    epc <= regWData;
                end
                if (regWrite && regAddr == AddrCause) begin
                    cause <= regWData[3:0];
                end
                if (regWrite && regAddr == AddrTval) begin
                    tval <= regWData;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------------------

    always_comb begin
        case (regAddr)
            AddrTvec:    regRData = {tvecBase, 2'b00};
            AddrScratch: regRData = scratch;
            AddrEpc:     regRData = epc;
            AddrCause:   regRData = word_t'(cause);
            AddrTval:    regRData = tval;
            default:     regRData = '0;
        endcase
    end

    assign handlerPc = {tvecBase, 2'b00};

    // Entry follows the single-cycle trap pulse
    trapEnterIsPulse: assert property (
        @(posedge clk) disable iff (rst) trapEnter |=> !trapEnter
    );

endmodule

`default_nettype wire

//--- privilegeControl.sv
// Current privilege, mstatus and medeleg; picks the trap target and the next pc on trap or return
`timescale 1ns/10ps
`default_nettype none

module privilegeControl (
    input  logic               clk,
    input  logic               rst,

    // Register access from the bus port
    input  logic               regWrite,
    input  csrPkg::csrAddr_t   regAddr,
    input  csrPkg::word_t      regWData,
    output csrPkg::word_t      regRData,

    // Trap and return events
    input  logic               trapValid,
    input  csrPkg::cause_t     trapCause,
    input  logic               trapReturn,
    input  csrPkg::privilege_t returnPriv,

    // From the two trap levels
    input  csrPkg::word_t      mHandlerPc,
    input  csrPkg::word_t      sHandlerPc,
    input  csrPkg::word_t      mEpc,
    input  csrPkg::word_t      sEpc,

    output logic               trapToMachine,
    output logic               trapToSupervisor,
    output csrPkg::word_t      nextPc,
    output csrPkg::privilege_t privilege
);
    import csrPkg::*;

    localparam csrAddr_t AddrMstatus = levelAddr(PrivMachine, OffStatus);
    localparam csrAddr_t AddrMedeleg = levelAddr(PrivMachine, OffEdeleg);
    localparam csrAddr_t AddrSstatus = levelAddr(PrivSupervisor, OffStatus);

    word_t      mstatus;
    word_t      medeleg;
    word_t      nextStatus;
    privilege_t nextPrivilege;
    privilege_t mppPriv;
    logic       delegated;
    logic       mretTaken;
    logic       sretTaken;

    // ------------------------------------------------------------------------
    // Event decode
    // ------------------------------------------------------------------------

    assign delegated        = medeleg[trapCause];
    assign trapToMachine    = trapValid && !delegated;
    assign trapToSupervisor = trapValid && delegated;

    assign mretTaken = trapReturn && (returnPriv == PrivMachine);
    assign sretTaken = trapReturn && (returnPriv == PrivSupervisor);

    // Reserved mpp value 2 returns to user
    assign mppPriv = (mstatus[StMppHi:StMppLo] == 2'b10)
                   ? PrivUser
                   : privilege_t'(mstatus[StMppHi:StMppLo]);

    // ------------------------------------------------------------------------
    // Next status and privilege
    // ------------------------------------------------------------------------

    // Trap or return owns mstatus in its cycle, a bus write only lands otherwise
    always_comb begin
        nextStatus    = mstatus;
        nextPrivilege = privilege;
        if (trapToMachine) begin
            nextStatus[StMpie]           = mstatus[StMie];
            nextStatus[StMie]            = 1'b0;
            nextStatus[StMppHi:StMppLo]  = privilege;
            nextPrivilege                = PrivMachine;
        end else if (trapToSupervisor) begin
            nextStatus[StSpie] = mstatus[StSie];
            nextStatus[StSie]  = 1'b0;
            nextStatus[StSpp]  = privilege[0];
            nextPrivilege      = PrivSupervisor;
        end else if (mretTaken) begin
            nextStatus[StMie]           = mstatus[StMpie];
            nextStatus[StMpie]          = 1'b1;
            nextStatus[StMppHi:StMppLo] = PrivUser;
            nextPrivilege               = mppPriv;
        end else if (sretTaken) begin
            nextStatus[StSie]  = mstatus[StSpie];
            nextStatus[StSpie] = 1'b1;
            nextStatus[StSpp]  = 1'b0;
            nextPrivilege      = mstatus[StSpp] ? PrivSupervisor : PrivUser;
        end else if (regWrite && regAddr == AddrMstatus) begin
            nextStatus = regWData & MstatusMask;
        end else if (regWrite && regAddr == AddrSstatus) begin
            nextStatus = (mstatus & ~SstatusMask) | (regWData & SstatusMask);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            privilege <= PrivMachine;
            mstatus   <= '0;
            medeleg   <= '0;
        end else begin
            privilege <= nextPrivilege;
            mstatus   <= nextStatus;
            if (regWrite && regAddr == AddrMedeleg) begin
                medeleg <= regWData;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------------

    always_comb begin
        case (regAddr)
            AddrMstatus: regRData = mstatus;
            AddrSstatus: regRData = mstatus & SstatusMask;
            AddrMedeleg: regRData = medeleg;
            default:     regRData = '0;
        endcase
    end

    // Handler on entry, epc of the level left on return
    always_comb begin
        if (trapToMachine) begin
            nextPc = mHandlerPc;
        end else if (trapToSupervisor) begin
            nextPc = sHandlerPc;
        end else if (mretTaken) begin
            nextPc = mEpc;
        end else if (sretTaken) begin
            nextPc = sEpc;
        end else begin
            nextPc = '0;
        end
    end

    privilegeLegal: assert property (
        @(posedge clk) disable iff (rst) privilege != 2'b10
    );

    trapAndReturnExclusive: assert property (
        @(posedge clk) disable iff (rst) !(trapValid && trapReturn)
    );

endmodule

`default_nettype wire

//--- csrBusPort.sv
// Wishbone classic slave for CSR access; owns ack, the read merge, cycle and identity registers
`timescale 1ns/10ps
`default_nettype none

module csrBusPort #(
    parameter csrPkg::word_t HartId = '0
) (
    input  logic             clk,
    input  logic             rst,

    // Wishbone slave
    input  logic             wbCyc,
    input  logic             wbStb,
    input  logic             wbWe,
    input  csrPkg::csrAddr_t wbAdr,
    input  csrPkg::word_t    wbDatW,
    output csrPkg::word_t    wbDatR,
    output logic             wbAck,

    // Read returns of the register units
    input  csrPkg::word_t    privRData,
    input  csrPkg::word_t    machineRData,
    input  csrPkg::word_t    supervisorRData,

    // Write path to the register units
    output logic             regWrite,
    output csrPkg::csrAddr_t regAddr,
    output csrPkg::word_t    regWData
);
    import csrPkg::*;

    logic [63:0] cycleCount;
    word_t       ownRData;
    logic        request;

    assign request = wbCyc && wbStb;

    // ------------------------------------------------------------------------
    // Handshake
    // ------------------------------------------------------------------------

    // One ack cycle per request, then at least one idle cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            wbAck <= 1'b0;
        end else begin
            wbAck <= request && !wbAck;
        end
    end

    // Master still holds address and data during ack
    assign regWrite = wbAck && request && wbWe;
    assign regAddr  = wbAdr;
    assign regWData = wbDatW;

    // ------------------------------------------------------------------------
    // Counter and identity registers
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            cycleCount <= '0;
        end else begin
            cycleCount <= cycleCount + 64'd1;
        end
    end

    always_comb begin
        case (wbAdr)
            AddrMisa:    ownRData = MisaValue;
            AddrMhartid: ownRData = HartId;
            AddrCycle:   ownRData = cycleCount[31:0];
            AddrCycleh:  ownRData = cycleCount[63:32];
            default:     ownRData = '0;
        endcase
    end

    // Units return zero for addresses they do not own
    assign wbDatR = ownRData | privRData | machineRData | supervisorRData;

    // Ack only answers a request seen on the previous edge and still held
    ackFollowsRequest: assert property (
        @(posedge clk) disable iff (rst) wbAck |-> $past(request) && request
    );

endmodule

`default_nettype wire

//--- csrPkg.sv
// Shared CSR types, address map, status field positions and constants; imported by every unit
`default_nettype none

package csrPkg;

    // ------------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------------

    // CSR values, pcs and Wishbone data lines
    typedef logic [31:0] word_t;

    // Wishbone address is the CSR number
    typedef logic [11:0] csrAddr_t;

    // Offset inside one privilege level's block
    typedef logic [7:0] csrOffset_t;

    // Exception code only, no interrupt bit
    typedef logic [3:0] cause_t;

    typedef enum logic [1:0] {
        PrivUser       = 2'd0,
        PrivSupervisor = 2'd1,
        PrivMachine    = 2'd3
    } privilege_t;

    // ------------------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------------------

    // Offsets within a level's block
    localparam csrOffset_t OffStatus  = 8'h00;
    localparam csrOffset_t OffEdeleg  = 8'h02;
    localparam csrOffset_t OffTvec    = 8'h05;
    localparam csrOffset_t OffScratch = 8'h40;
    localparam csrOffset_t OffEpc     = 8'h41;
    localparam csrOffset_t OffCause   = 8'h42;
    localparam csrOffset_t OffTval    = 8'h43;

    // Registers outside the trap blocks
    localparam csrAddr_t AddrMisa    = 12'h301;
    localparam csrAddr_t AddrMhartid = 12'hF14;
    localparam csrAddr_t AddrCycle   = 12'hC00;
    localparam csrAddr_t AddrCycleh  = 12'hC80;

    // Block base is the privilege value times 256
    function automatic csrAddr_t levelAddr(privilege_t priv, csrOffset_t off);
        return {2'b00, priv, off};
    endfunction

    // ------------------------------------------------------------------------
    // Status fields
    // ------------------------------------------------------------------------

    localparam int StSie   = 1;
    localparam int StMie   = 3;
    localparam int StSpie  = 5;
    localparam int StMpie  = 7;
    localparam int StSpp   = 8;
    localparam int StMppLo = 11;
    localparam int StMppHi = 12;

    // Bits kept in mstatus, everything else reads zero
    localparam word_t MstatusMask = (word_t'(1) << StSie) | (word_t'(1) << StMie)
                                  | (word_t'(1) << StSpie) | (word_t'(1) << StMpie)
                                  | (word_t'(1) << StSpp) | (word_t'(1) << StMppLo)
                                  | (word_t'(1) << StMppHi);

    // Supervisor view of the same register
    localparam word_t SstatusMask = (word_t'(1) << StSie) | (word_t'(1) << StSpie)
                                  | (word_t'(1) << StSpp);

    // RV32 with I and S extensions
    localparam word_t MisaValue = 32'h4004_0100;

endpackage

`default_nettype wire
